//--- rtl/dcache_pkg.sv
package dcache_pkg;

	localparam int s_offset = 5; // byte offset bits within a line.
	localparam int s_mask = 2**s_offset;
	localparam int s_line = 8*s_mask;

	typedef logic [31:0] addr_t;
	typedef logic [s_line-1:0] line_t;
	typedef logic [s_mask-1:0] mask_t;

	// request carried from the port into stage 2.
	typedef struct packed {
		addr_t address;
		logic mem_read;
		logic mem_write;
		mask_t byte_enable;
		line_t wdata;
	} cache_cw_t;

	// miss handling steps of the controller.
	typedef enum logic [1:0] {
		compare,
		write_back,
		allocate,
		replay
	} ctrl_state_t;

endpackage : dcache_pkg

//--- rtl/cache_array.sv
`timescale 1ns/1ps

module cache_array #(
	parameter int s_index = 3,
	parameter int width = 1
) (
	input logic clk,
	input logic rst,
	input logic read,
	input logic load,
	input logic [s_index-1:0] rindex,
	input logic [s_index-1:0] windex,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	localparam int num_sets = 2**s_index;

	logic [width-1:0] data [num_sets];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_sets; i++) begin
				data[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (read) begin
				// write-first on a same-set access.
				dataout <= (load && rindex == windex) ? datain : data[rindex];
			end
			if (load) begin
				data[windex] <= datain;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) load |-> !$isunknown(windex));

endmodule : cache_array

//--- rtl/data_array.sv
`timescale 1ns/1ps

module data_array #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic read,
	input dcache_pkg::mask_t write_en,
	input logic [s_index-1:0] rindex,
	input logic [s_index-1:0] windex,
	input dcache_pkg::line_t datain,
	output dcache_pkg::line_t dataout
);

	import dcache_pkg::*;

	localparam int num_sets = 2**s_index;

	line_t data [num_sets];
	logic same_set;

	assign same_set = (rindex == windex);

	// one byte lane per enable bit.
	always_ff @(posedge clk) begin
		for (int i = 0; i < s_mask; i++) begin
			if (read) begin
				if (write_en[i] && same_set) begin
					dataout[8*i +: 8] <= datain[8*i +: 8]; // forwarded byte.
				end else begin
					dataout[8*i +: 8] <= data[rindex][8*i +: 8];
				end
			end
			if (write_en[i]) begin
				data[windex][8*i +: 8] <= datain[8*i +: 8];
			end
		end
	end

endmodule : data_array

//--- rtl/dcache_dp.sv
`timescale 1ns/1ps

module dcache_dp #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input dcache_pkg::addr_t mem_address,
	input dcache_pkg::mask_t mem_byte_enable,
	input dcache_pkg::line_t mem_wdata,
	input logic load_pipeline,
	input logic read_data,
	input logic [1:0] load_data,
	input logic [1:0] load_tag,
	input logic [1:0] set_valid,
	input logic [1:0] set_dirty,
	input logic [1:0] clear_dirty,
	input logic load_lru,
	input logic fill_sel,
	input logic victim_sel,
	input dcache_pkg::line_t pmem_rdata,
	output dcache_pkg::line_t mem_rdata,
	output dcache_pkg::addr_t pmem_address,
	output dcache_pkg::line_t pmem_wdata,
	output logic hit,
	output logic [1:0] way_hit,
	output logic victim_dirty,
	output logic lru_way,
	output dcache_pkg::cache_cw_t pipe_cw
);

	import dcache_pkg::*;

	localparam int s_tag = 32 - s_offset - s_index;

	typedef logic [s_tag-1:0] tag_t;
	typedef logic [s_index-1:0] index_t;

	cache_cw_t cw_in;
	index_t rindex;
	index_t windex;
	tag_t pipe_tag;
	line_t line_in;
	line_t line_out [2];
	tag_t tag_out [2];
	mask_t wmask [2];
	logic [1:0] valid_out;
	logic [1:0] dirty_out;

	assign cw_in = '{
		address: mem_address,
		mem_read: mem_read,
		mem_write: mem_write,
		byte_enable: mem_byte_enable,
		wdata: mem_wdata
	};

	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			pipe_cw <= cw_in;
		end
	end

	// all writes go to the set held in stage 2.
	assign windex = pipe_cw.address[s_offset +: s_index];
	assign rindex = load_pipeline ? mem_address[s_offset +: s_index] : windex;
	assign pipe_tag = pipe_cw.address[31 -: s_tag];
	assign line_in = fill_sel ? pmem_rdata : pipe_cw.wdata;

	for (genvar w = 0; w < 2; w++) begin : g_way
		assign wmask[w] = !load_data[w] ? '0 : (fill_sel ? '1 : pipe_cw.byte_enable);

		data_array #(.s_index(s_index)) data_i (
			.clk(clk),
			.read(read_data),
			.write_en(wmask[w]),
			.rindex(rindex),
			.windex(windex),
			.datain(line_in),
			.dataout(line_out[w])
		);

		cache_array #(.s_index(s_index), .width(s_tag)) tag_i (
			.clk(clk),
			.rst(rst),
			.read(read_data),
			.load(load_tag[w]),
			.rindex(rindex),
			.windex(windex),
			.datain(pipe_tag),
			.dataout(tag_out[w])
		);

		cache_array #(.s_index(s_index), .width(1)) valid_i (
			.clk(clk),
			.rst(rst),
			.read(read_data),
			.load(set_valid[w]),
			.rindex(rindex),
			.windex(windex),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		cache_array #(.s_index(s_index), .width(1)) dirty_i (
			.clk(clk),
			.rst(rst),
			.read(read_data),
			.load(set_dirty[w] | clear_dirty[w]),
			.rindex(rindex),
			.windex(windex),
			.datain(set_dirty[w]), // set wins, a clear writes zero.
			.dataout(dirty_out[w])
		);

		assign way_hit[w] = valid_out[w] && (tag_out[w] == pipe_tag);
	end

	// lru bit names the way to evict next.
	cache_array #(.s_index(s_index), .width(1)) lru_i (
		.clk(clk),
		.rst(rst),
		.read(read_data),
		.load(load_lru),
		.rindex(rindex),
		.windex(windex),
		.datain(way_hit[0]),
		.dataout(lru_way)
	);

	assign hit = |way_hit;
	assign mem_rdata = way_hit[1] ? line_out[1] : line_out[0];
	assign victim_dirty = dirty_out[lru_way];
	assign pmem_wdata = line_out[lru_way];
	assign pmem_address = victim_sel ? {tag_out[lru_way], windex, {s_offset{1'b0}}}
		: {pipe_cw.address[31:s_offset], {s_offset{1'b0}}};

	// a line is allocated only on a miss, so it lives in one way.
	assert property (@(posedge clk) disable iff (rst) !(way_hit[0] && way_hit[1]));

endmodule : dcache_dp

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input logic hit,
	input logic [1:0] way_hit,
	input logic victim_dirty,
	input logic lru_way,
	input logic pmem_resp,
	input dcache_pkg::cache_cw_t pipe_cw,
	output logic mem_ready,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic load_pipeline,
	output logic read_data,
	output logic [1:0] load_data,
	output logic [1:0] load_tag,
	output logic [1:0] set_valid,
	output logic [1:0] set_dirty,
	output logic [1:0] clear_dirty,
	output logic load_lru,
	output logic fill_sel,
	output logic victim_sel
);

	import dcache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic s2_valid; // stage 2 holds a live request.
	logic miss;
	logic fill;
	logic store_hit;
	logic [1:0] victim;

	assign miss = (state == compare) && s2_valid && !hit;
	assign mem_resp = (state == compare) && s2_valid && hit;
	assign mem_ready = (state == compare) && !(s2_valid && !hit);
	assign load_pipeline = mem_req && mem_ready;

	// arrays hold their outputs while a miss is in service.
	assign read_data = load_pipeline || (state == replay);

	assign victim = lru_way ? 2'b10 : 2'b01;
	assign fill = (state == allocate) && pmem_resp;
	assign store_hit = mem_resp && pipe_cw.mem_write;

	assign pmem_read = (state == allocate);
	assign pmem_write = (state == write_back);
	assign fill_sel = (state == allocate);
	assign victim_sel = (state == write_back);

	assign load_data = fill ? victim : (store_hit ? way_hit : 2'b00);
	assign set_dirty = store_hit ? way_hit : 2'b00;
	assign load_tag = fill ? victim : 2'b00;
	assign set_valid = fill ? victim : 2'b00;
	assign clear_dirty = fill ? victim : 2'b00;
	assign load_lru = mem_resp;

	always_comb begin
		state_next = state;
		unique case (state)
			compare: begin
				if (miss) begin
					state_next = victim_dirty ? write_back : allocate;
				end
			end
			write_back: begin
				if (pmem_resp) begin
					state_next = allocate;
				end
			end
			allocate: begin
				if (pmem_resp) begin
					state_next = replay;
				end
			end
			replay: state_next = compare; // arrays re-read, next cycle hits.
			default: state_next = compare;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= compare;
			s2_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (load_pipeline) begin
				s2_valid <= 1'b1;
			end else if (mem_resp) begin
				s2_valid <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));

	// the requester strobes only while the cache is ready.
	assert property (@(posedge clk) disable iff (rst) mem_req |-> mem_ready);

	// memory answers only an open request.
	assert property (@(posedge clk) disable iff (rst) pmem_resp |-> (pmem_read || pmem_write));

endmodule : dcache_ctrl

//--- rtl/dcache.sv
`timescale 1ns/1ps

module dcache #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input logic mem_read,
	input logic mem_write,
	input dcache_pkg::addr_t mem_address,
	input dcache_pkg::mask_t mem_byte_enable,
	input dcache_pkg::line_t mem_wdata,
	output logic mem_ready,
	output logic mem_resp,
	output dcache_pkg::line_t mem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output dcache_pkg::addr_t pmem_address,
	output dcache_pkg::line_t pmem_wdata,
	input logic pmem_resp,
	input dcache_pkg::line_t pmem_rdata
);

	import dcache_pkg::*;

	cache_cw_t pipe_cw;
	logic load_pipeline;
	logic read_data;
	logic [1:0] load_data;
	logic [1:0] load_tag;
	logic [1:0] set_valid;
	logic [1:0] set_dirty;
	logic [1:0] clear_dirty;
	logic load_lru;
	logic fill_sel;
	logic victim_sel;
	logic hit;
	logic [1:0] way_hit;
	logic victim_dirty;
	logic lru_way;

	dcache_ctrl #(.s_index(s_index)) ctrl (.*);

	dcache_dp #(.s_index(s_index)) dp (.*);

endmodule : dcache

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2.0);
			clk = ~clk;
		end
	end

endmodule : tb_clock

//--- bench/line_fill.svh
function automatic dcache_pkg::line_t fill_line(input dcache_pkg::addr_t address);
	dcache_pkg::line_t line;
	logic [31:0] word;
	for (int i = 0; i < 8; i++) begin
		word = (address ^ (i << 2)) * 32'h9e37_79b1; // every word depends on the whole address.
		line[32*i +: 32] = word ^ {address[31:5], 5'(i)};
	end
	return line;
endfunction

//--- bench/pmem_model.sv
`timescale 1ns/1ps

module pmem_model #(
	parameter int max_latency = 8,
	parameter logic [31:0] seed_init = 32'h1
) (
	input logic clk,
	input logic rst,
	input logic pmem_read,
	input logic pmem_write,
	input dcache_pkg::addr_t pmem_address,
	input dcache_pkg::line_t pmem_wdata,
	output logic pmem_resp,
	output dcache_pkg::line_t pmem_rdata
);

	import dcache_pkg::*;

	`include "line_fill.svh"

	line_t mem [addr_t]; // lines never written keep their fill pattern.
	integer seed;
	int waited;
	int delay;

	initial begin
		seed = seed_init;
		waited = 0;
		delay = 1;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
	end

	// one request at a time, the response strobe lasts a single cycle.
	always @(posedge clk) begin
		#1;
		pmem_resp = 1'b0;
		if (rst) begin
			waited = 0;
		end else if (pmem_read || pmem_write) begin
			if (waited == 0) begin
				delay = 1 + {$random(seed)} % max_latency; // new request.
			end
			waited++;
			if (waited >= delay) begin
				if (pmem_write) begin
					mem[pmem_address] = pmem_wdata;
				end else if (mem.exists(pmem_address)) begin
					pmem_rdata = mem[pmem_address];
				end else begin
					pmem_rdata = fill_line(pmem_address);
				end
				pmem_resp = 1'b1;
				waited = 0;
			end
		end
	end

endmodule : pmem_model

//--- bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

	import dcache_pkg::*;

	`include "line_fill.svh"

	localparam int s_index = 3;
	localparam int num_sets = 2**s_index;
	localparam int s_tag = 32 - s_offset - s_index;
	localparam int num_requests = 2000;
	localparam int max_latency = 8;
	localparam int timeout_cycles = num_requests * (4 + 2 * max_latency);

	typedef struct packed {
		logic is_read;
		logic is_hit;
		int unsigned cycle;
		int unsigned last_op;
		line_t data;
	} resp_exp_t;

	typedef struct packed {
		logic is_write;
		addr_t address;
		line_t data;
	} mem_op_t;

	logic clk;
	logic rst;
	logic mem_req;
	logic mem_read;
	logic mem_write;
	addr_t mem_address;
	mask_t mem_byte_enable;
	line_t mem_wdata;
	logic mem_ready;
	logic mem_resp;
	line_t mem_rdata;
	logic pmem_read;
	logic pmem_write;
	addr_t pmem_address;
	line_t pmem_wdata;
	logic pmem_resp;
	line_t pmem_rdata;

	integer seed;
	int unsigned cycle = 0;
	int issued;
	int req_count;
	int resp_count;
	int unsigned ops_pushed;
	int unsigned ops_seen;
	logic mem_busy; // a memory request is open.

	line_t ref_mem [addr_t];
	logic [s_tag-1:0] tag_m [num_sets][2];
	logic [1:0] valid_m [num_sets];
	logic [1:0] dirty_m [num_sets];
	logic lru_m [num_sets];
	resp_exp_t resp_q [$];
	mem_op_t op_q [$];
	logic [s_tag-1:0] tag_pool [4] = '{24'h000000, 24'h0001a5, 24'h7c3e01, 24'hfff0f0};

	tb_clock #(.period_ns(8)) clock_i (.clk(clk));

	pmem_model #(.max_latency(max_latency), .seed_init(32'hf304_86fc)) pmem_i (.*);

	dcache #(.s_index(s_index)) dcache_inst (.*);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopping at the first error.");
	endtask

	function automatic line_t ref_line(input addr_t line_addr);
		if (ref_mem.exists(line_addr)) begin
			return ref_mem[line_addr];
		end
		return fill_line(line_addr);
	endfunction

	function automatic line_t merge_bytes(input line_t old_line, input line_t new_line,
		input mask_t mask);
		line_t merged;
		merged = old_line;
		for (int i = 0; i < s_mask; i++) begin
			if (mask[i]) begin
				merged[8*i +: 8] = new_line[8*i +: 8];
			end
		end
		return merged;
	endfunction

	// two-way set model, the lru bit names the way to fill next.
	task automatic model_request(input addr_t address, input logic is_write, input mask_t mask,
		input line_t wdata);
		logic [s_index-1:0] idx;
		logic [s_tag-1:0] tag;
		addr_t line_addr;
		int way;
		logic is_hit;
		resp_exp_t exp;
		mem_op_t op;
		idx = address[s_offset +: s_index];
		tag = address[31 -: s_tag];
		line_addr = {address[31:s_offset], {s_offset{1'b0}}};
		is_hit = 1'b0;
		way = lru_m[idx];
		for (int w = 0; w < 2; w++) begin
			if (valid_m[idx][w] && tag_m[idx][w] == tag) begin
				is_hit = 1'b1;
				way = w;
			end
		end
		if (!is_hit) begin
			if (dirty_m[idx][way]) begin
				op.is_write = 1'b1;
				op.address = {tag_m[idx][way], idx, {s_offset{1'b0}}};
				op.data = ref_line(op.address);
				op_q.push_back(op);
				ops_pushed++;
			end
			op.is_write = 1'b0;
			op.address = line_addr;
			op.data = '0;
			op_q.push_back(op);
			ops_pushed++;
			tag_m[idx][way] = tag;
			valid_m[idx][way] = 1'b1;
			dirty_m[idx][way] = 1'b0;
		end
		lru_m[idx] = (way == 0);
		if (is_write) begin
			dirty_m[idx][way] = 1'b1;
			ref_mem[line_addr] = merge_bytes(ref_line(line_addr), wdata, mask);
		end
		exp.is_read = !is_write;
		exp.is_hit = is_hit;
		exp.cycle = cycle;
		exp.last_op = ops_pushed;
		exp.data = ref_line(line_addr);
		resp_q.push_back(exp);
	endtask

	task automatic drive_request();
		addr_t address;
		logic is_write;
		line_t wdata;
		address = $random(seed);
		address[31 -: s_tag] = tag_pool[{$random(seed)} % 4];
		is_write = ({$random(seed)} % 10) < 4;
		for (int i = 0; i < 8; i++) begin
			wdata[32*i +: 32] = $random(seed);
		end
		mem_address = address;
		mem_read = !is_write;
		mem_write = is_write;
		mem_byte_enable = $random(seed);
		mem_wdata = wdata;
		mem_req = 1'b1;
		model_request(address, is_write, mem_byte_enable, wdata);
		issued++;
	endtask

	task automatic check_response();
		resp_exp_t exp;
		logic ready_exp;
		ready_exp = 1'b1;
		if (resp_q.size() > 0) begin
			exp = resp_q[0];
			if (exp.cycle != cycle && !exp.is_hit && !mem_resp) begin
				ready_exp = 1'b0; // a miss in stage 2 holds the requester off.
			end
		end
		assert (mem_ready === ready_exp) else report_failure($sformatf(
			"FAILED mem_ready: got %h, expected %h", mem_ready, ready_exp));
		if (mem_req) begin
			req_count++;
		end
		if (mem_resp) begin
			assert (resp_q.size() > 0) else report_failure("mem_resp with no request outstanding");
			exp = resp_q.pop_front();
			resp_count++;
			if (exp.is_read) begin
				assert (mem_rdata === exp.data) else report_failure($sformatf(
					"FAILED mem_rdata: got %h, expected %h", mem_rdata, exp.data));
			end
			if (exp.is_hit) begin
				assert (cycle == exp.cycle + 1) else report_failure($sformatf(
					"FAILED mem_resp cycle: got %h, expected %h", cycle, exp.cycle + 1));
			end else begin
				assert (cycle > exp.cycle + 1 && ops_seen == exp.last_op && !mem_busy)
					else report_failure("a miss was answered before its memory traffic ended");
			end
		end
	endtask

	task automatic check_memory();
		mem_op_t op;
		assert (!(pmem_read && pmem_write))
			else report_failure("pmem_read and pmem_write are high together");
		if ((pmem_read || pmem_write) && !mem_busy) begin
			assert (op_q.size() > 0) else report_failure("memory request that no miss explains");
			op = op_q.pop_front();
			ops_seen++;
			assert (pmem_write === op.is_write) else report_failure($sformatf(
				"FAILED pmem_write: got %h, expected %h", pmem_write, op.is_write));
			assert (pmem_address === op.address) else report_failure($sformatf(
				"FAILED pmem_address: got %h, expected %h", pmem_address, op.address));
			if (op.is_write) begin
				assert (pmem_wdata === op.data) else report_failure($sformatf(
					"FAILED pmem_wdata: got %h, expected %h", pmem_wdata, op.data));
			end
			mem_busy = 1'b1;
		end
		if (pmem_resp) begin
			mem_busy = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			report_failure($sformatf("timeout, the run did not end within %0d cycles",
				timeout_cycles));
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			check_response();
			check_memory();
		end
	end

	initial begin
		seed = 32'hf304_86fc;
		issued = 0;
		req_count = 0;
		resp_count = 0;
		ops_pushed = 0;
		ops_seen = 0;
		mem_busy = 1'b0;
		rst = 1'b1;
		mem_req = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_byte_enable = '0;
		mem_wdata = '0;
		for (int s = 0; s < num_sets; s++) begin
			tag_m[s][0] = '0;
			tag_m[s][1] = '0;
			valid_m[s] = 2'b00;
			dirty_m[s] = 2'b00;
			lru_m[s] = 1'b0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		assert (mem_ready && !mem_resp && !pmem_read && !pmem_write)
			else report_failure("cache outputs are not idle after reset");
		while (issued < num_requests) begin
			@(posedge clk);
			#1;
			mem_req = 1'b0;
			if (mem_ready && ({$random(seed)} % 5 != 0)) begin
				drive_request(); // strobe only while ready.
			end
		end
		@(posedge clk);
		#1;
		mem_req = 1'b0;
		wait (resp_count == num_requests);
		repeat (4) @(posedge clk);
		if (resp_count == req_count && resp_q.size() == 0 && op_q.size() == 0 && !mem_busy) begin
			$display("** PASS **");
		end else begin
			report_failure("request and response counts differ at the end of the run");
		end
		$finish;
	end

endmodule : dcache_tb

//--- list.f
+incdir+bench
rtl/dcache_pkg.sv
rtl/cache_array.sv
rtl/data_array.sv
rtl/dcache_dp.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
bench/tb_clock.sv
bench/pmem_model.sv
bench/dcache_tb.sv
